/* hw/macrx_crc32.sv */
//----------------------------------------------------------
// Reflected IEEE CRC-32, one byte per clock, LSB first
// start reloads the seed and may come with the first byte
// crc holds the inverted register until the next start
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module macrx_crc32 (
    input  wire                      clk_125m,
    input  wire                      rst_125m,
    input  wire                      start,
    input  wire macrx_frame_pkg::byte_t din,
    input  wire                      din_vld,
    output macrx_frame_pkg::word32_t crc
);

    import macrx_frame_pkg::*;

    localparam word32_t POLY_REFL = 32'hEDB8_8320;

    word32_t crc_reg;
    word32_t crc_seed;
    word32_t crc_next;

    // Bitwise fold of one byte
    always_comb begin
        crc_seed = start ? '1 : crc_reg;
        crc_next = crc_seed;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ din[i]) begin
                crc_next = (crc_next >> 1) ^ POLY_REFL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            crc_reg <= '1;
        end else if (din_vld) begin
            crc_reg <= crc_next;
        end else if (start) begin
            crc_reg <= '1;
        end
    end

    assign crc = ~crc_reg;

endmodule

`default_nettype wire

/* hw/macrx_frame_check.sv */
//----------------------------------------------------------
// Tick, length and CRC checks of one frame at a time
// done comes two cycles after the end_byte beat
// Flags and status hold until the following done
// Previous tick starts at zero after reset
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module macrx_frame_check (
    input  wire                            clk_125m,
    input  wire                            rst_125m,
    input  wire macrx_frame_pkg::frame_beat_t frame_beat,
    input  wire                            self_cfg_err,
    output macrx_status_pkg::frame_result_t result
);

    import macrx_frame_pkg::*;
    import macrx_status_pkg::*;

    logic         cfg_meta;
    logic         cfg_sync;
    logic [2:0]   body_cnt;
    logic [2:0]   idx_now;
    word16_t      tick_cur;
    word16_t      tick_prev;
    status_word_t status_cap;
    word32_t      fcs_cap;
    word32_t      crc_val;
    logic         crc_start;
    logic         crc_vld;
    logic         beat_end;
    logic         end_pending;
    err_flags_t   err_next;

    assign crc_start = frame_beat.valid && frame_beat.first;
    assign crc_vld   = frame_beat.valid && (frame_beat.role == role_body ||
                       frame_beat.role == role_status_hi ||
                       frame_beat.role == role_status_lo);
    assign beat_end  = frame_beat.valid && frame_beat.role == role_end_byte;
    assign idx_now   = frame_beat.first ? 3'd0 : body_cnt;

    macrx_crc32 u_crc32 (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .start    (crc_start),
        .din      (frame_beat.data),
        .din_vld  (crc_vld),
        .crc      (crc_val)
    );

    //----------------------------------------------------------
    // Field capture
    //----------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            cfg_meta <= 1'b0;
            cfg_sync <= 1'b0;
            body_cnt <= '0;
            tick_cur <= '0;
        end else begin
            cfg_meta <= self_cfg_err;
            cfg_sync <= cfg_meta;
            if (frame_beat.valid && frame_beat.role == role_body) begin
                // Only the first few indices matter, so saturate
                body_cnt <= (idx_now == 3'd7) ? 3'd7 : idx_now + 3'd1;
                if (idx_now == 3'(TICK_OFFSET)) begin
                    tick_cur[15:8] <= frame_beat.data;
                end
                if (idx_now == 3'(TICK_OFFSET + 1)) begin
                    tick_cur[7:0] <= frame_beat.data;
                end
            end
        end
    end

    always_ff @(posedge clk_125m) begin
        if (frame_beat.valid && frame_beat.role == role_status_hi) begin
            status_cap[15:8] <= frame_beat.data;
        end
        if (frame_beat.valid && frame_beat.role == role_status_lo) begin
            status_cap[7:0] <= frame_beat.data;
        end
        // FCS arrives MSB first
        if (frame_beat.valid && frame_beat.role == role_fcs) begin
            fcs_cap <= {fcs_cap[23:0], frame_beat.data};
        end
        if (beat_end) begin
            err_next.cfg_err  <= cfg_sync;
            err_next.len_err  <= !frame_beat.eop_seen || frame_beat.data != END_BYTE;
            err_next.tick_err <= tick_cur != tick_prev + 16'd1;
            err_next.crc_err  <= fcs_cap != crc_val;
        end
    end

    //----------------------------------------------------------
    // Result
    //----------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            end_pending <= 1'b0;
            tick_prev   <= '0;
            result      <= '0;
        end else begin
            end_pending <= beat_end;
            result.done <= end_pending;
            if (end_pending) begin
                result.flags  <= err_next;
                result.status <= status_cap;
                tick_prev     <= tick_cur;
            end
        end
    end

    a_done_single : assert property (
        @(posedge clk_125m) disable iff (!rst_125m)
        result.done |=> !result.done
    );

endmodule

`default_nettype wire

/* hw/macrx_frame_pkg.sv */
//----------------------------------------------------------
// Frame format constants and the beat types of the byte path
// Body layout puts the tick at B[4..5] and the length at
// B[6..7], both high byte first, with a length of at least 8
// Two status bytes, four FCS bytes and the end byte follow
//----------------------------------------------------------
`default_nettype none

package macrx_frame_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word16_t;
    typedef logic [31:0] word32_t;

    // Beat as seen on the PCS side and on the FIFO side
    typedef struct packed {
        logic  valid;
        logic  sop;
        logic  eop;
        byte_t data;
    } pcs_beat_t;

    // Position of a byte after the SFD
    typedef enum logic [2:0] {
        role_body,
        role_status_hi,
        role_status_lo,
        role_fcs,
        role_end_byte
    } body_role_t;

    // Beat from frame sync to the check and output stages
    typedef struct packed {
        logic       valid;
        logic       first;
        body_role_t role;
        logic       eop_seen;
        byte_t      data;
    } frame_beat_t;

    //----------------------------------------------------------
    // Format constants
    //----------------------------------------------------------
    localparam byte_t   PREAMBLE_BYTE = 8'h55;
    localparam byte_t   SFD_BYTE      = 8'hD5;
    localparam byte_t   END_BYTE      = 8'hFD;
    localparam int      TICK_OFFSET   = 4;
    localparam int      LEN_OFFSET    = 6;
    localparam int      FCS_BYTES     = 4;
    // Length assumed until the first one is captured
    localparam word16_t LEN_RESET     = 16'h0078;

endpackage

`default_nettype wire

/* hw/macrx_frame_sync.sv */
//----------------------------------------------------------
// Input side of the receiver
// Frames start on sop with exactly PREAMBLE_LEN bytes of 0x55
// and one SFD, anything else drops the frame silently
// The frame closes at the end position even without eop
// A sop inside the body is not honoured
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module macrx_frame_sync #(
    parameter int PREAMBLE_LEN = 7
) (
    input  wire                          clk_125m,
    input  wire                          rst_125m,
    input  wire macrx_frame_pkg::pcs_beat_t pcs_in,
    output macrx_frame_pkg::frame_beat_t frame_beat
);

    import macrx_frame_pkg::*;

    localparam int PRE_W   = $clog2(PREAMBLE_LEN + 1);
    localparam int END_POS = FCS_BYTES + 2;
    localparam int TAIL_W  = $clog2(END_POS + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_body,
        st_trailer
    } sync_state_t;

    sync_state_t       state;
    logic [PRE_W-1:0]  pre_cnt;
    word16_t           body_idx;
    word16_t           len_reg;
    logic [TAIL_W-1:0] tail_pos;
    word16_t           len_cur;
    logic              last_body;
    logic              at_end;
    body_role_t        tail_role;

    //----------------------------------------------------------
    // Length and trailer position decode
    //----------------------------------------------------------
    // Low length byte is used in the same cycle it arrives
    always_comb begin
        len_cur = len_reg;
        if (body_idx == word16_t'(LEN_OFFSET + 1)) begin
            len_cur = {len_reg[15:8], pcs_in.data};
        end
        last_body = (body_idx >= word16_t'(LEN_OFFSET + 1)) &&
                    (body_idx + 16'd1 == len_cur);
    end

    assign at_end = (tail_pos == TAIL_W'(END_POS));

    always_comb begin
        if (tail_pos == '0) begin
            tail_role = role_status_hi;
        end else if (tail_pos == TAIL_W'(1)) begin
            tail_role = role_status_lo;
        end else if (at_end) begin
            tail_role = role_end_byte;
        end else begin
            tail_role = role_fcs;
        end
    end

    //----------------------------------------------------------
    // Frame FSM and beat register
    //----------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            state      <= st_idle;
            pre_cnt    <= '0;
            body_idx   <= '0;
            len_reg    <= LEN_RESET;
            tail_pos   <= '0;
            frame_beat <= '0;
        end else begin
            frame_beat.valid    <= 1'b0;
            frame_beat.first    <= 1'b0;
            frame_beat.role     <= role_body;
            frame_beat.eop_seen <= 1'b0;
            frame_beat.data     <= pcs_in.data;
            if (pcs_in.valid) begin
                case (state)
                    st_idle: begin
                        if (pcs_in.sop && pcs_in.data == PREAMBLE_BYTE) begin
                            state   <= st_preamble;
                            pre_cnt <= PRE_W'(1);
                        end
                    end
                    st_preamble: begin
                        if (pcs_in.eop) begin
                            state <= st_idle;
                        end else if (pcs_in.data == PREAMBLE_BYTE &&
                                     pre_cnt != PRE_W'(PREAMBLE_LEN)) begin
                            pre_cnt <= pre_cnt + 1'b1;
                        end else if (pcs_in.data == SFD_BYTE &&
                                     pre_cnt == PRE_W'(PREAMBLE_LEN)) begin
                            state    <= st_body;
                            body_idx <= '0;
                        end else begin
                            state <= st_idle;
                        end
                    end
                    st_body: begin
                        frame_beat.valid <= 1'b1;
                        frame_beat.first <= (body_idx == '0);
                        body_idx         <= body_idx + 16'd1;
                        if (body_idx == word16_t'(LEN_OFFSET)) begin
                            len_reg[15:8] <= pcs_in.data;
                        end
                        if (body_idx == word16_t'(LEN_OFFSET + 1)) begin
                            len_reg[7:0] <= pcs_in.data;
                        end
                        // Early eop closes the frame as a short one
                        if (pcs_in.eop) begin
                            frame_beat.role <= role_end_byte;
                            state           <= st_idle;
                        end else if (last_body) begin
                            state    <= st_trailer;
                            tail_pos <= '0;
                        end
                    end
                    default: begin
                        frame_beat.valid <= 1'b1;
                        frame_beat.role  <= tail_role;
                        tail_pos         <= tail_pos + 1'b1;
                        if (at_end) begin
                            frame_beat.eop_seen <= pcs_in.eop;
                            state               <= st_idle;
                        end else if (pcs_in.eop) begin
                            frame_beat.role <= role_end_byte;
                            state           <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    a_role_needs_valid : assert property (
        @(posedge clk_125m) disable iff (!rst_125m)
        frame_beat.role != role_body |-> frame_beat.valid
    );

endmodule

`default_nettype wire

/* hw/macrx_status_pkg.sv */
//----------------------------------------------------------
// Per-frame check result carried from check to output
// Flags and status are only meaningful while done is high
// or held after it
//----------------------------------------------------------
`default_nettype none

package macrx_status_pkg;

    // Peer status, S[0] in the upper byte
    typedef logic [15:0] status_word_t;

    typedef struct packed {
        logic cfg_err;
        logic len_err;
        logic tick_err;
        logic crc_err;
    } err_flags_t;

    typedef struct packed {
        logic         done;
        err_flags_t   flags;
        status_word_t status;
    } frame_result_t;

endpackage

`default_nettype wire

/* hw/macrx_top.sv */
//----------------------------------------------------------
// Byte-serial frame receiver, single 125 MHz domain
// No back-pressure, every valid input beat is taken
// Input end byte to output eop is five cycles
// A new sop must wait until the previous trailer is out
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module macrx_top #(
    parameter int PREAMBLE_LEN = 7
) (
    input  wire                          clk_125m,
    input  wire                          rst_125m,
    input  wire macrx_frame_pkg::pcs_beat_t pcs_in,
    input  wire                          self_cfg_err,
    output macrx_frame_pkg::pcs_beat_t   fifo_out
);

    import macrx_frame_pkg::*;
    import macrx_status_pkg::*;

    frame_beat_t   frame_beat;
    frame_result_t result;

    macrx_frame_sync #(
        .PREAMBLE_LEN (PREAMBLE_LEN)
    ) u_frame_sync (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .pcs_in     (pcs_in),
        .frame_beat (frame_beat)
    );

    macrx_frame_check u_frame_check (
        .clk_125m     (clk_125m),
        .rst_125m     (rst_125m),
        .frame_beat   (frame_beat),
        .self_cfg_err (self_cfg_err),
        .result       (result)
    );

    macrx_trailer_out u_trailer_out (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .frame_beat (frame_beat),
        .result     (result),
        .fifo_out   (fifo_out)
    );

endmodule

`default_nettype wire

/* hw/macrx_trailer_out.sv */
//----------------------------------------------------------
// Output side, extension card trailer layout
// Byte 1 is S[0], byte 2 is S[1][7:4] then the four flags
// Trailer bytes take priority over any body beat
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module macrx_trailer_out (
    input  wire                              clk_125m,
    input  wire                              rst_125m,
    input  wire macrx_frame_pkg::frame_beat_t   frame_beat,
    input  wire macrx_status_pkg::frame_result_t result,
    output macrx_frame_pkg::pcs_beat_t       fifo_out
);

    import macrx_frame_pkg::*;

    typedef enum logic [1:0] {
        out_pass,
        out_trail_hi,
        out_trail_lo
    } out_state_t;

    out_state_t state;
    pcs_beat_t  body_q;

    // Body beats, one cycle behind the frame beat
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            body_q <= '0;
        end else begin
            body_q.valid <= frame_beat.valid && frame_beat.role == role_body;
            body_q.sop   <= frame_beat.valid && frame_beat.first &&
                            frame_beat.role == role_body;
            body_q.eop   <= 1'b0;
            body_q.data  <= frame_beat.data;
        end
    end

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            state <= out_pass;
        end else begin
            case (state)
                out_pass:     state <= result.done ? out_trail_hi : out_pass;
                out_trail_hi: state <= out_trail_lo;
                default:      state <= out_pass;
            endcase
        end
    end

    //----------------------------------------------------------
    // Output mux
    //----------------------------------------------------------
    always_comb begin
        case (state)
            out_trail_hi: fifo_out = {1'b1, 1'b0, 1'b0, result.status[15:8]};
            out_trail_lo: fifo_out = {1'b1, 1'b0, 1'b1, result.status[7:4],
                                      result.flags};
            default:      fifo_out = body_q;
        endcase
    end

    a_eop_valid : assert property (
        @(posedge clk_125m) disable iff (!rst_125m)
        fifo_out.eop |-> fifo_out.valid
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tb_macrx -o tb_macrx_sim

out=$(./obj_dir/tb_macrx_sim)
echo "$out"

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    exit 1
fi

/* tb.f */
hw/macrx_frame_pkg.sv
hw/macrx_status_pkg.sv
hw/macrx_frame_sync.sv
hw/macrx_crc32.sv
hw/macrx_frame_check.sv
hw/macrx_trailer_out.sv
hw/macrx_top.sv
test/tb_macrx.sv

/* test/macrx_tests.txt */
# P cfg preamble_count sfd | D cfg n bytes (body then S0 S1) | F cfg fcs_xor_mask
# E cfg eop byte | O n expected bytes, sop on first and eop on last | T test_name
P 0 7 d5
D 0 10 10 11 12 13 00 01 00 08 a5 3c
F 0 0
E 0 1 fd
O 10 10 11 12 13 00 01 00 08 a5 30
T good_frame
P 0 5 d5
T short_preamble
P 0 7 d4
T missing_sfd
# a nonzero FCS mask acts as a corrupted body byte
P 0 7 d5
D 0 10 20 21 22 23 00 02 00 08 5a c7
F 0 00000001
E 0 1 fd
O 10 20 21 22 23 00 02 00 08 5a c1
T crc_error
P 0 7 d5
D 0 10 30 31 32 33 00 05 00 08 11 f0
F 0 0
E 0 1 fd
O 10 30 31 32 33 00 05 00 08 11 f2
T tick_jump
P 0 7 d5
D 0 10 40 41 42 43 00 06 00 08 22 e5
F 0 0
E 0 1 fd
O 10 40 41 42 43 00 06 00 08 22 e0
T tick_next
P 0 7 d5
D 0 10 50 51 52 53 00 07 00 08 33 d9
F 0 0
E 0 1 fc
E 0 0 77
O 10 50 51 52 53 00 07 00 08 33 d4
T bad_end_byte
P 0 7 d5
D 0 10 60 61 62 63 00 08 00 08 44 b1
F 0 0
E 0 0 fd
E 0 0 77
O 10 60 61 62 63 00 08 00 08 44 b4
T missing_eop
P 1 7 d5
D 1 10 70 71 72 73 00 09 00 08 66 93
F 1 0
E 1 1 fd
O 10 70 71 72 73 00 09 00 08 66 98
T cfg_error

/* test/tb_macrx.sv */
//----------------------------------------------------------
// Frame receiver testbench driven from a text file
// Beats are driven 1 ns after the rising edge
// The FCS is computed here from the bytes actually sent
// Outputs are collected on the falling edge
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_macrx;

    import macrx_frame_pkg::*;

    logic       clk_125m;
    logic       rst_125m;
    pcs_beat_t  pcs_in;
    logic       self_cfg_err;
    pcs_beat_t  fifo_out;

    integer      seed;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    int          pass_count = 0;
    int          test_count = 0;
    logic [9:0]  got_q[$];
    logic [9:0]  exp_q[$];
    logic [31:0] crc_acc;

    macrx_top #(
        .PREAMBLE_LEN (7)
    ) macrx_top_inst (
        .clk_125m     (clk_125m),
        .rst_125m     (rst_125m),
        .pcs_in       (pcs_in),
        .self_cfg_err (self_cfg_err),
        .fifo_out     (fifo_out)
    );

    initial begin
        clk_125m = 1'b0;
        forever #4 clk_125m = ~clk_125m;
    end

    // Collector with one entry per valid output beat
    always @(negedge clk_125m) begin
        if (rst_125m && fifo_out.valid) begin
            got_q.push_back({fifo_out.sop, fifo_out.eop, fifo_out.data});
        end
    end

    always @(posedge clk_125m) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // One byte of the reflected CRC-32 with polynomial 0xEDB88320
    function automatic logic [31:0] crc_fold(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int j = 0; j < 8; j++) begin
            r = (r[0] ^ b[j]) ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        return r;
    endfunction

    task automatic send_beat(input logic sop, input logic eop, input logic [7:0] data,
                             input logic cfg);
        @(posedge clk_125m);
        #1;
        pcs_in       = {1'b1, sop, eop, data};
        self_cfg_err = cfg;
    endtask

    // Noise byte with valid low
    task automatic idle_cycle(input logic cfg);
        integer rnd;
        rnd = $random(seed);
        @(posedge clk_125m);
        #1;
        pcs_in       = {1'b0, 1'b0, 1'b0, rnd[7:0]};
        self_cfg_err = cfg;
    endtask

    task automatic check_test(input logic [191:0] name);
        int errs;
        int n;
        errs = 0;
        // A dropped frame must also swallow the bytes behind it
        if (exp_q.size() == 0) begin
            for (int k = 0; k < 12; k++) begin
                send_beat(1'b0, k == 11, 8'(k), 1'b0);
            end
        end
        repeat (8) idle_cycle(1'b0);
        n = exp_q.size();
        assert (got_q.size() == n) else begin
            $display("Test %0s: expected %0d output beats but saw %0d", name, n, got_q.size());
            errs++;
        end
        for (int k = 0; k < n && k < got_q.size(); k++) begin
            assert (got_q[k] == exp_q[k]) else begin
                $display("** Error: %0s fifo_out {sop,eop,data} beat %0d got %h expected %h",
                         name, k, got_q[k], exp_q[k]);
                errs++;
            end
        end
        test_count++;
        if (errs == 0) begin
            pass_count++;
            $display("Test %0s: passed", name);
        end else begin
            error_count += errs;
            $display("Test %0s: failed with %0d errors", name, errs);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    initial begin
        integer           fd;
        integer           r;
        int               lines;
        int               cnt;
        logic [191:0]     tag;
        logic [191:0]     name;
        logic [1023:0]    line;
        logic [31:0]      cfg;
        logic [31:0]      eop;
        logic [31:0]      val;
        logic [31:0]      mask;
        logic [31:0]      fcs;
        pcs_in       = '0;
        self_cfg_err = 1'b0;
        rst_125m     = 1'b0;
        crc_acc      = '1;
        seed         = 32'hc70e_1d40;
        fd = $fopen("test/macrx_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/macrx_tests.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            lines = 0;
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                lines++;
            end
            $fclose(fd);
            cycle_limit = 40 * lines + 20;
            repeat (10) @(posedge clk_125m);
            #1 rst_125m = 1'b1;
            fd = $fopen("test/macrx_tests.txt", "r");
            while ($fscanf(fd, " %s", tag) == 1) begin
                if (tag == "#") begin
                    r = $fgets(line, fd);
                end else if (tag == "P") begin
                    r = $fscanf(fd, " %h %d %h", cfg, cnt, val);
                    crc_acc = '1;
                    for (int k = 0; k < cnt; k++) begin
                        send_beat(k == 0, 1'b0, 8'h55, cfg[0]);
                    end
                    send_beat(1'b0, 1'b0, val[7:0], cfg[0]);
                end else if (tag == "D") begin
                    r = $fscanf(fd, " %h %d", cfg, cnt);
                    for (int k = 0; k < cnt; k++) begin
                        r = $fscanf(fd, " %h", val);
                        crc_acc = crc_fold(crc_acc, val[7:0]);
                        send_beat(1'b0, 1'b0, val[7:0], cfg[0]);
                    end
                end else if (tag == "F") begin
                    r = $fscanf(fd, " %h %h", cfg, mask);
                    // FCS goes out most significant byte first
                    fcs = ~crc_acc ^ mask;
                    for (int k = 0; k < 4; k++) begin
                        send_beat(1'b0, 1'b0, fcs[31-8*k -: 8], cfg[0]);
                    end
                end else if (tag == "E") begin
                    r = $fscanf(fd, " %h %h %h", cfg, eop, val);
                    send_beat(1'b0, eop[0], val[7:0], cfg[0]);
                end else if (tag == "O") begin
                    r = $fscanf(fd, " %d", cnt);
                    for (int k = 0; k < cnt; k++) begin
                        r = $fscanf(fd, " %h", val);
                        exp_q.push_back({k == 0, k == cnt - 1, val[7:0]});
                    end
                end else if (tag == "T") begin
                    r = $fscanf(fd, " %s", name);
                    check_test(name);
                end else begin
                    $display("Unknown line type %0s in the test file", tag);
                    error_count++;
                end
            end
            $fclose(fd);
            $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                     test_count, pass_count, test_count - pass_count, error_count);
            if (error_count == 0 && test_count > 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
